// File: emu_pkg.sv
package emu_pkg;

    // AXI-lite widths
    typedef logic [11:0] axil_addr_t;
    typedef logic [31:0] axil_data_t;
    typedef logic [3:0]  axil_strb_t;
    typedef logic [1:0]  axil_resp_t;

    // emulation state
    typedef logic [63:0] cycle_t;

    // word index into the ideal memory
    typedef logic [9:0]  mem_index_t;

    localparam int MEM_DEPTH = 1024;

    // response codes
    localparam axil_resp_t RESP_OKAY   = 2'b00;
    localparam axil_resp_t RESP_SLVERR = 2'b10;

    // CSR map
    // stat bit 0 is halt
    localparam axil_addr_t REG_STAT     = 12'h000;
    localparam axil_addr_t REG_CYCLE_LO = 12'h008;
    localparam axil_addr_t REG_CYCLE_HI = 12'h00c;

    // processor store to this address halts the design
    localparam logic [31:0] TRIGGER_ADDR = 32'h0000_000c;

    localparam axil_strb_t FULL_STRB = 4'hf;

endpackage

// File: axil_slave_port.sv
`timescale 1ns/1ps

module axil_slave_port (
    input  logic                clk,
    input  logic                rst,

    input  logic                s_arvalid,
    output logic                s_arready,
    input  emu_pkg::axil_addr_t s_araddr,
    output logic                s_rvalid,
    input  logic                s_rready,
    output emu_pkg::axil_data_t s_rdata,
    output emu_pkg::axil_resp_t s_rresp,

    input  logic                s_awvalid,
    output logic                s_awready,
    input  emu_pkg::axil_addr_t s_awaddr,
    input  logic                s_wvalid,
    output logic                s_wready,
    input  emu_pkg::axil_data_t s_wdata,
    input  emu_pkg::axil_strb_t s_wstrb,
    output logic                s_bvalid,
    input  logic                s_bready,
    output emu_pkg::axil_resp_t s_bresp,

    output emu_pkg::axil_addr_t rd_addr,
    input  emu_pkg::axil_data_t rd_data,
    output logic                wr_en,
    output emu_pkg::axil_addr_t wr_addr,
    output emu_pkg::axil_data_t wr_data,
    output emu_pkg::axil_strb_t wr_strb,
    input  logic                wr_err
);
    import emu_pkg::*;

    logic rd_pend;
    logic aw_held;
    logic w_held;
    logic rd_sample;

    // read data is taken one edge after the address
    assign rd_sample = rd_pend && !s_rvalid;

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_pend  <= 1'b0;
            s_rvalid <= 1'b0;
        end else begin
            if (s_arvalid && s_arready) begin
                rd_pend <= 1'b1;
            end
            if (rd_sample) begin
                s_rvalid <= 1'b1;
            end
            if (s_rvalid && s_rready) begin
                rd_pend  <= 1'b0;
                s_rvalid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (s_arvalid && s_arready) begin
            rd_addr <= s_araddr;
        end
        if (rd_sample) begin
            s_rdata <= rd_data;
        end
    end

    assign s_arready = !rd_pend;
    assign s_rresp   = RESP_OKAY;

    // hold off a new write while the previous response is unaccepted
    assign wr_en = aw_held && w_held && !s_bvalid;

    always_ff @(posedge clk) begin
        if (rst) begin
            aw_held  <= 1'b0;
            w_held   <= 1'b0;
            s_bvalid <= 1'b0;
        end else begin
            if (s_awvalid && s_awready) begin
                aw_held <= 1'b1;
            end
            if (s_wvalid && s_wready) begin
                w_held <= 1'b1;
            end
            if (wr_en) begin
                aw_held  <= 1'b0;
                w_held   <= 1'b0;
                s_bvalid <= 1'b1;
            end
            if (s_bvalid && s_bready) begin
                s_bvalid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (s_awvalid && s_awready) begin
            wr_addr <= s_awaddr;
        end
        if (s_wvalid && s_wready) begin
            wr_data <= s_wdata;
            wr_strb <= s_wstrb;
        end
        if (wr_en) begin
            s_bresp <= wr_err ? RESP_SLVERR : RESP_OKAY;
        end
    end

    assign s_awready = !aw_held;
    assign s_wready  = !w_held;

endmodule

// File: emu_csr.sv
`timescale 1ns/1ps

module emu_csr (
    input  logic                clk,
    input  logic                rst,

    input  emu_pkg::axil_addr_t rd_addr,
    output emu_pkg::axil_data_t rd_data,

    input  logic                wr_en,
    input  emu_pkg::axil_addr_t wr_addr,
    input  emu_pkg::axil_data_t wr_data,
    input  emu_pkg::axil_strb_t wr_strb,
    output logic                wr_err,

    input  logic [31:0]         cpu_addr,
    input  logic                cpu_mem_write,

    output logic                halt
);
    import emu_pkg::*;

    cycle_t cycle;
    logic   trigger;
    logic   do_write;
    logic   wr_stat;
    logic   wr_cycle_lo;
    logic   wr_cycle_hi;

    // only full-word register writes are legal
    assign wr_err   = wr_strb != FULL_STRB;
    assign do_write = wr_en && !wr_err;

    assign wr_stat     = do_write && (wr_addr == REG_STAT);
    assign wr_cycle_lo = do_write && (wr_addr == REG_CYCLE_LO);
    assign wr_cycle_hi = do_write && (wr_addr == REG_CYCLE_HI);

    // processor store to the trigger address
    assign trigger = cpu_mem_write && (cpu_addr == TRIGGER_ADDR);

    always_ff @(posedge clk) begin
        if (rst) begin
            halt <= 1'b0;
        end else if (trigger) begin
            halt <= 1'b1;
        end else if (wr_stat) begin
            halt <= wr_data[0];
        end
    end

    // counter is free running until halted, then host loadable
    always_ff @(posedge clk) begin
        if (rst) begin
            cycle <= '0;
        end else if (!halt) begin
            cycle <= cycle + 64'd1;
        end else begin
            if (wr_cycle_lo) begin
                cycle[31:0] <= wr_data;
            end
            if (wr_cycle_hi) begin
                cycle[63:32] <= wr_data;
            end
        end
    end

    always_comb begin
        case (rd_addr)
            REG_STAT:     rd_data = {31'd0, halt};
            REG_CYCLE_LO: rd_data = cycle[31:0];
            REG_CYCLE_HI: rd_data = cycle[63:32];
            default:      rd_data = '0;
        endcase
    end

endmodule

// File: emu_mem.sv
`timescale 1ns/1ps

module emu_mem (
    input  logic                clk,
    input  logic                halt,

    input  emu_pkg::axil_addr_t host_raddr,
    output emu_pkg::axil_data_t host_rdata,
    input  logic                host_wr_en,
    input  emu_pkg::axil_addr_t host_waddr,
    input  emu_pkg::axil_data_t host_wdata,
    input  emu_pkg::axil_strb_t host_wstrb,
    output logic                host_wr_err,

    input  logic [31:0]         cpu_pc,
    output emu_pkg::axil_data_t cpu_instr,
    input  logic [31:0]         cpu_addr,
    input  logic                cpu_mem_write,
    input  emu_pkg::axil_data_t cpu_wdata,
    input  emu_pkg::axil_strb_t cpu_wstrb,
    output emu_pkg::axil_data_t cpu_rdata
);
    import emu_pkg::*;

    axil_data_t mem [MEM_DEPTH];

    logic       mux_wen;
    mem_index_t mux_waddr;
    axil_data_t mux_wdata;
    axil_strb_t mux_wstrb;
    mem_index_t mux_raddr;
    axil_data_t mux_rdata;

    // host owns the write and data read ports while halted
    assign mux_wen   = halt ? host_wr_en         : cpu_mem_write;
    assign mux_waddr = halt ? host_waddr[11:2]   : cpu_addr[11:2];
    assign mux_wdata = halt ? host_wdata         : cpu_wdata;
    assign mux_wstrb = halt ? host_wstrb         : cpu_wstrb;
    assign mux_raddr = halt ? host_raddr[11:2]   : cpu_addr[11:2];

    always_ff @(posedge clk) begin
        for (int i = 0; i < 4; i++) begin
            if (mux_wen && mux_wstrb[i]) begin
                mem[mux_waddr][i*8 +: 8] <= mux_wdata[i*8 +: 8];
            end
        end
    end

    assign cpu_instr = mem[mem_index_t'(cpu_pc[11:2])];
    assign mux_rdata = mem[mux_raddr];

    assign cpu_rdata  = mux_rdata;
    assign host_rdata = mux_rdata;

    // a host write while running never reaches the array
    assign host_wr_err = !halt;

endmodule

// File: emu_top.sv
`timescale 1ns/1ps

module emu_top (
    input  logic                clk,
    input  logic                rst,

    input  logic                csr_arvalid,
    output logic                csr_arready,
    input  emu_pkg::axil_addr_t csr_araddr,
    output logic                csr_rvalid,
    input  logic                csr_rready,
    output emu_pkg::axil_data_t csr_rdata,
    output emu_pkg::axil_resp_t csr_rresp,
    input  logic                csr_awvalid,
    output logic                csr_awready,
    input  emu_pkg::axil_addr_t csr_awaddr,
    input  logic                csr_wvalid,
    output logic                csr_wready,
    input  emu_pkg::axil_data_t csr_wdata,
    input  emu_pkg::axil_strb_t csr_wstrb,
    output logic                csr_bvalid,
    input  logic                csr_bready,
    output emu_pkg::axil_resp_t csr_bresp,

    input  logic                mem_arvalid,
    output logic                mem_arready,
    input  emu_pkg::axil_addr_t mem_araddr,
    output logic                mem_rvalid,
    input  logic                mem_rready,
    output emu_pkg::axil_data_t mem_rdata,
    output emu_pkg::axil_resp_t mem_rresp,
    input  logic                mem_awvalid,
    output logic                mem_awready,
    input  emu_pkg::axil_addr_t mem_awaddr,
    input  logic                mem_wvalid,
    output logic                mem_wready,
    input  emu_pkg::axil_data_t mem_wdata,
    input  emu_pkg::axil_strb_t mem_wstrb,
    output logic                mem_bvalid,
    input  logic                mem_bready,
    output emu_pkg::axil_resp_t mem_bresp,

    input  logic [31:0]         cpu_pc,
    output emu_pkg::axil_data_t cpu_instr,
    input  logic [31:0]         cpu_addr,
    input  logic                cpu_mem_write,
    input  emu_pkg::axil_data_t cpu_wdata,
    input  emu_pkg::axil_strb_t cpu_wstrb,
    output emu_pkg::axil_data_t cpu_rdata
);
    import emu_pkg::*;

    axil_addr_t csr_rd_addr;
    axil_data_t csr_rd_data;
    logic       csr_wr_en;
    axil_addr_t csr_wr_addr;
    axil_data_t csr_wr_data;
    axil_strb_t csr_wr_strb;
    logic       csr_wr_err;

    axil_addr_t mem_rd_addr;
    axil_data_t mem_rd_data;
    logic       mem_wr_en;
    axil_addr_t mem_wr_addr;
    axil_data_t mem_wr_data;
    axil_strb_t mem_wr_strb;
    logic       mem_wr_err;

    logic halt;

    axil_slave_port u_csr_port (
        .clk       (clk),
        .rst       (rst),
        .s_arvalid (csr_arvalid),
        .s_arready (csr_arready),
        .s_araddr  (csr_araddr),
        .s_rvalid  (csr_rvalid),
        .s_rready  (csr_rready),
        .s_rdata   (csr_rdata),
        .s_rresp   (csr_rresp),
        .s_awvalid (csr_awvalid),
        .s_awready (csr_awready),
        .s_awaddr  (csr_awaddr),
        .s_wvalid  (csr_wvalid),
        .s_wready  (csr_wready),
        .s_wdata   (csr_wdata),
        .s_wstrb   (csr_wstrb),
        .s_bvalid  (csr_bvalid),
        .s_bready  (csr_bready),
        .s_bresp   (csr_bresp),
        .rd_addr   (csr_rd_addr),
        .rd_data   (csr_rd_data),
        .wr_en     (csr_wr_en),
        .wr_addr   (csr_wr_addr),
        .wr_data   (csr_wr_data),
        .wr_strb   (csr_wr_strb),
        .wr_err    (csr_wr_err)
    );

    axil_slave_port u_mem_port (
        .clk       (clk),
        .rst       (rst),
        .s_arvalid (mem_arvalid),
        .s_arready (mem_arready),
        .s_araddr  (mem_araddr),
        .s_rvalid  (mem_rvalid),
        .s_rready  (mem_rready),
        .s_rdata   (mem_rdata),
        .s_rresp   (mem_rresp),
        .s_awvalid (mem_awvalid),
        .s_awready (mem_awready),
        .s_awaddr  (mem_awaddr),
        .s_wvalid  (mem_wvalid),
        .s_wready  (mem_wready),
        .s_wdata   (mem_wdata),
        .s_wstrb   (mem_wstrb),
        .s_bvalid  (mem_bvalid),
        .s_bready  (mem_bready),
        .s_bresp   (mem_bresp),
        .rd_addr   (mem_rd_addr),
        .rd_data   (mem_rd_data),
        .wr_en     (mem_wr_en),
        .wr_addr   (mem_wr_addr),
        .wr_data   (mem_wr_data),
        .wr_strb   (mem_wr_strb),
        .wr_err    (mem_wr_err)
    );

    emu_csr u_csr (
        .clk           (clk),
        .rst           (rst),
        .rd_addr       (csr_rd_addr),
        .rd_data       (csr_rd_data),
        .wr_en         (csr_wr_en),
        .wr_addr       (csr_wr_addr),
        .wr_data       (csr_wr_data),
        .wr_strb       (csr_wr_strb),
        .wr_err        (csr_wr_err),
        .cpu_addr      (cpu_addr),
        .cpu_mem_write (cpu_mem_write),
        .halt          (halt)
    );

    emu_mem u_mem (
        .clk           (clk),
        .halt          (halt),
        .host_raddr    (mem_rd_addr),
        .host_rdata    (mem_rd_data),
        .host_wr_en    (mem_wr_en),
        .host_waddr    (mem_wr_addr),
        .host_wdata    (mem_wr_data),
        .host_wstrb    (mem_wr_strb),
        .host_wr_err   (mem_wr_err),
        .cpu_pc        (cpu_pc),
        .cpu_instr     (cpu_instr),
        .cpu_addr      (cpu_addr),
        .cpu_mem_write (cpu_mem_write),
        .cpu_wdata     (cpu_wdata),
        .cpu_wstrb     (cpu_wstrb),
        .cpu_rdata     (cpu_rdata)
    );

endmodule

// File: emu_props.sv
`timescale 1ns/1ps

module emu_props (
    input logic clk,
    input logic rst,
    input logic s_arready,
    input logic s_rvalid,
    input logic s_rready,
    input logic s_bvalid,
    input logic s_bready,
    input logic wr_en
);
    int failures = 0;

    rvalid_held: assert property (@(posedge clk) disable iff (rst)
        s_rvalid && !s_rready |=> s_rvalid)
        else begin
            $error("rvalid dropped before rready");
            failures++;
        end

    bvalid_held: assert property (@(posedge clk) disable iff (rst)
        s_bvalid && !s_bready |=> s_bvalid)
        else begin
            $error("bvalid dropped before bready");
            failures++;
        end

    wr_en_single: assert property (@(posedge clk) disable iff (rst)
        wr_en |=> !wr_en)
        else begin
            $error("wr_en longer than one cycle");
            failures++;
        end

    // no new read accepted while a response waits
    arready_low: assert property (@(posedge clk) disable iff (rst)
        s_rvalid |-> !s_arready)
        else begin
            $error("arready high while rvalid");
            failures++;
        end

endmodule

bind axil_slave_port emu_props u_props (
    .clk       (clk),
    .rst       (rst),
    .s_arready (s_arready),
    .s_rvalid  (s_rvalid),
    .s_rready  (s_rready),
    .s_bvalid  (s_bvalid),
    .s_bready  (s_bready),
    .wr_en     (wr_en)
);

// File: tb_emu_checker.sv
`timescale 1ns/1ps

module tb_emu_checker (
    input  logic                clk,
    input  logic                rst,
    input  logic [1:0]          arvalid,
    input  logic [1:0]          arready,
    input  emu_pkg::axil_addr_t araddr [2],
    input  logic [1:0]          rvalid,
    input  logic [1:0]          rready,
    input  emu_pkg::axil_data_t rdata [2],
    input  emu_pkg::axil_resp_t rresp [2],
    input  logic [1:0]          awvalid,
    input  logic [1:0]          awready,
    input  emu_pkg::axil_addr_t awaddr [2],
    input  logic [1:0]          wvalid,
    input  logic [1:0]          wready,
    input  emu_pkg::axil_data_t wdata [2],
    input  emu_pkg::axil_strb_t wstrb [2],
    input  logic [1:0]          bvalid,
    input  logic [1:0]          bready,
    input  emu_pkg::axil_resp_t bresp [2],
    input  logic [31:0]         cpu_pc,
    input  emu_pkg::axil_data_t cpu_instr,
    input  logic [31:0]         cpu_addr,
    input  logic                cpu_mem_write,
    input  emu_pkg::axil_data_t cpu_wdata,
    input  emu_pkg::axil_strb_t cpu_wstrb,
    input  emu_pkg::axil_data_t cpu_rdata,
    input  logic                cpu_check
);
    import emu_pkg::*;

    int         checks;
    int         errors;
    logic       halt_m;
    axil_data_t mem_m   [MEM_DEPTH];
    axil_strb_t known_m [MEM_DEPTH];
    axil_data_t lo_m;
    axil_data_t hi_m;
    logic       lo_known;
    logic       hi_known;
    axil_addr_t rd_a [2];
    axil_addr_t wr_a [2];
    axil_data_t wr_d [2];
    axil_strb_t wr_s [2];

    initial begin
        checks = 0;
        errors = 0;
        for (int i = 0; i < MEM_DEPTH; i++) begin
            mem_m[i]   = '0;
            known_m[i] = '0;
        end
    end

    task automatic check_value(input string what, input axil_data_t exp, input axil_data_t act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("Error: %s expected 0x%0h actual 0x%0h", what, exp, act);
        end
    endtask

    task automatic check_resp(input string what, input axil_resp_t exp, input axil_resp_t act);
        check_value(what, axil_data_t'(exp), axil_data_t'(act));
    endtask

    task automatic store_word(input mem_index_t idx, input axil_data_t d, input axil_strb_t s);
        for (int b = 0; b < 4; b++) begin
            if (s[b]) begin
                mem_m[idx][b*8 +: 8] = d[b*8 +: 8];
            end
        end
        known_m[idx] = known_m[idx] | s;
    endtask

    // first read of a halted counter half records it and later reads must match
    task automatic counter_half(input string what, inout logic known, inout axil_data_t val,
                                input axil_data_t act);
        if (known) begin
            check_value(what, val, act);
        end else if (halt_m) begin
            val   = act;
            known = 1'b1;
        end
    endtask

    task automatic set_halt(input logic h);
        if (h != halt_m) begin
            lo_known = 1'b0;
            hi_known = 1'b0;
        end
        halt_m = h;
    endtask

    task automatic csr_read_done();
        check_resp("csr_rresp", RESP_OKAY, rresp[0]);
        case (rd_a[0])
            REG_STAT:     check_value("csr_rdata stat", {31'd0, halt_m}, rdata[0]);
            REG_CYCLE_LO: counter_half("csr_rdata cycle_lo", lo_known, lo_m, rdata[0]);
            REG_CYCLE_HI: counter_half("csr_rdata cycle_hi", hi_known, hi_m, rdata[0]);
            default:      check_value("csr_rdata unmapped", 32'd0, rdata[0]);
        endcase
    endtask

    task automatic csr_write_done();
        if (wr_s[0] != FULL_STRB) begin
            check_resp("csr_bresp", RESP_SLVERR, bresp[0]);
        end else begin
            check_resp("csr_bresp", RESP_OKAY, bresp[0]);
            if (wr_a[0] == REG_STAT) begin
                set_halt(wr_d[0][0]);
            end else if (halt_m && wr_a[0] == REG_CYCLE_LO) begin
                lo_m     = wr_d[0];
                lo_known = 1'b1;
            end else if (halt_m && wr_a[0] == REG_CYCLE_HI) begin
                hi_m     = wr_d[0];
                hi_known = 1'b1;
            end
        end
    endtask

    always @(posedge clk) begin
        if (rst) begin
            halt_m   = 1'b0;
            lo_known = 1'b0;
            hi_known = 1'b0;
        end else begin
            for (int p = 0; p < 2; p++) begin
                if (arvalid[p] && arready[p]) begin
                    rd_a[p] = araddr[p];
                end
                if (awvalid[p] && awready[p]) begin
                    wr_a[p] = awaddr[p];
                end
                if (wvalid[p] && wready[p]) begin
                    wr_d[p] = wdata[p];
                    wr_s[p] = wstrb[p];
                end
            end
            if (rvalid[0] && rready[0]) begin
                csr_read_done();
            end
            if (bvalid[0] && bready[0]) begin
                csr_write_done();
            end
            if (rvalid[1] && rready[1]) begin
                check_resp("mem_rresp", RESP_OKAY, rresp[1]);
                if (known_m[rd_a[1][11:2]] == FULL_STRB) begin
                    check_value("mem_rdata", mem_m[rd_a[1][11:2]], rdata[1]);
                end
            end
            if (bvalid[1] && bready[1]) begin
                check_resp("mem_bresp", halt_m ? RESP_OKAY : RESP_SLVERR, bresp[1]);
                if (halt_m) begin
                    store_word(wr_a[1][11:2], wr_d[1], wr_s[1]);
                end
            end
            if (cpu_check) begin
                if (known_m[cpu_pc[11:2]] == FULL_STRB) begin
                    check_value("cpu_instr", mem_m[cpu_pc[11:2]], cpu_instr);
                end
                if (!halt_m && known_m[cpu_addr[11:2]] == FULL_STRB) begin
                    check_value("cpu_rdata", mem_m[cpu_addr[11:2]], cpu_rdata);
                end
            end
            if (cpu_mem_write && !halt_m) begin
                store_word(cpu_addr[11:2], cpu_wdata, cpu_wstrb);
            end
            if (cpu_mem_write && cpu_addr == TRIGGER_ADDR) begin
                set_halt(1'b1);
            end
        end
    end

endmodule

// File: tb_emu_top.sv
`timescale 1ns/1ps

module tb_emu_top;
    import emu_pkg::*;

    localparam int CSR_P      = 0;
    localparam int MEM_P      = 1;
    localparam int WAIT_LIMIT = 32;
    // transactions in the sequence, worst-case cycles each, then margin
    localparam int NUM_TXN    = 90;
    localparam int TXN_CYCLES = 24;
    localparam int RUN_LIMIT  = NUM_TXN * TXN_CYCLES + 300;

    logic clk;
    logic rst;

    logic [1:0] arvalid;
    logic [1:0] arready;
    logic [1:0] rvalid;
    logic [1:0] rready;
    logic [1:0] awvalid;
    logic [1:0] awready;
    logic [1:0] wvalid;
    logic [1:0] wready;
    logic [1:0] bvalid;
    logic [1:0] bready;
    axil_addr_t araddr [2];
    axil_addr_t awaddr [2];
    axil_data_t rdata  [2];
    axil_data_t wdata  [2];
    axil_strb_t wstrb  [2];
    axil_resp_t rresp  [2];
    axil_resp_t bresp  [2];

    logic [31:0] cpu_pc;
    logic [31:0] cpu_addr;
    logic        cpu_mem_write;
    axil_data_t  cpu_wdata;
    axil_strb_t  cpu_wstrb;
    axil_data_t  cpu_instr;
    axil_data_t  cpu_rdata;
    logic        cpu_check;

    logic [31:0] lfsr;
    int          fails;
    int          cycles;
    axil_addr_t  mem_addrs [8];

    emu_top u_emu_top (
        .clk           (clk),
        .rst           (rst),
        .csr_arvalid   (arvalid[0]),
        .csr_arready   (arready[0]),
        .csr_araddr    (araddr[0]),
        .csr_rvalid    (rvalid[0]),
        .csr_rready    (rready[0]),
        .csr_rdata     (rdata[0]),
        .csr_rresp     (rresp[0]),
        .csr_awvalid   (awvalid[0]),
        .csr_awready   (awready[0]),
        .csr_awaddr    (awaddr[0]),
        .csr_wvalid    (wvalid[0]),
        .csr_wready    (wready[0]),
        .csr_wdata     (wdata[0]),
        .csr_wstrb     (wstrb[0]),
        .csr_bvalid    (bvalid[0]),
        .csr_bready    (bready[0]),
        .csr_bresp     (bresp[0]),
        .mem_arvalid   (arvalid[1]),
        .mem_arready   (arready[1]),
        .mem_araddr    (araddr[1]),
        .mem_rvalid    (rvalid[1]),
        .mem_rready    (rready[1]),
        .mem_rdata     (rdata[1]),
        .mem_rresp     (rresp[1]),
        .mem_awvalid   (awvalid[1]),
        .mem_awready   (awready[1]),
        .mem_awaddr    (awaddr[1]),
        .mem_wvalid    (wvalid[1]),
        .mem_wready    (wready[1]),
        .mem_wdata     (wdata[1]),
        .mem_wstrb     (wstrb[1]),
        .mem_bvalid    (bvalid[1]),
        .mem_bready    (bready[1]),
        .mem_bresp     (bresp[1]),
        .cpu_pc        (cpu_pc),
        .cpu_instr     (cpu_instr),
        .cpu_addr      (cpu_addr),
        .cpu_mem_write (cpu_mem_write),
        .cpu_wdata     (cpu_wdata),
        .cpu_wstrb     (cpu_wstrb),
        .cpu_rdata     (cpu_rdata)
    );

    tb_emu_checker u_checker (
        .clk           (clk),
        .rst           (rst),
        .arvalid       (arvalid),
        .arready       (arready),
        .araddr        (araddr),
        .rvalid        (rvalid),
        .rready        (rready),
        .rdata         (rdata),
        .rresp         (rresp),
        .awvalid       (awvalid),
        .awready       (awready),
        .awaddr        (awaddr),
        .wvalid        (wvalid),
        .wready        (wready),
        .wdata         (wdata),
        .wstrb         (wstrb),
        .bvalid        (bvalid),
        .bready        (bready),
        .bresp         (bresp),
        .cpu_pc        (cpu_pc),
        .cpu_instr     (cpu_instr),
        .cpu_addr      (cpu_addr),
        .cpu_mem_write (cpu_mem_write),
        .cpu_wdata     (cpu_wdata),
        .cpu_wstrb     (cpu_wstrb),
        .cpu_rdata     (cpu_rdata),
        .cpu_check     (cpu_check)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #10 clk = ~clk;
        end
    end

    // fibonacci lfsr with taps 32 22 2 1 stepped once per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        logic        fb;
        v = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            v    = {v[30:0], fb};
        end
        return v;
    endfunction

    function automatic string port_name(input int p);
        return (p == MEM_P) ? "mem" : "csr";
    endfunction

    task automatic write_txn(input int p, input axil_addr_t a, input axil_data_t d,
                             input axil_strb_t s);
        int   n;
        int   w_delay;
        int   stall;
        logic aw_done;
        logic w_done;
        n       = 0;
        aw_done = 1'b0;
        w_done  = 1'b0;
        w_delay = rand_bits(2);
        @(posedge clk);
        awaddr[p]  <= a;
        awvalid[p] <= 1'b1;
        wdata[p]   <= d;
        wstrb[p]   <= s;
        if (w_delay == 0) begin
            wvalid[p] <= 1'b1;
        end
        while (!(aw_done && w_done) && n < WAIT_LIMIT) begin
            @(posedge clk);
            n++;
            if (awvalid[p] && awready[p]) begin
                aw_done    = 1'b1;
                awvalid[p] <= 1'b0;
            end
            if (wvalid[p] && wready[p]) begin
                w_done    = 1'b1;
                wvalid[p] <= 1'b0;
            end else if (!w_done && n >= w_delay) begin
                wvalid[p] <= 1'b1;
            end
        end
        if (!(aw_done && w_done)) begin
            $display("%s port never accepted the write address or data", port_name(p));
            fails++;
            awvalid[p] <= 1'b0;
            wvalid[p]  <= 1'b0;
        end else begin
            stall = rand_bits(2);
            repeat (stall) @(posedge clk);
            bready[p] <= 1'b1;
            n = 0;
            do begin
                @(posedge clk);
                n++;
            end while (!(bvalid[p] && bready[p]) && n < WAIT_LIMIT);
            bready[p] <= 1'b0;
            if (!(bvalid[p] && bready[p])) begin
                $display("%s port gave no write response", port_name(p));
                fails++;
            end
        end
    endtask

    task automatic read_txn(input int p, input axil_addr_t a);
        int n;
        int stall;
        n = 0;
        @(posedge clk);
        araddr[p]  <= a;
        arvalid[p] <= 1'b1;
        do begin
            @(posedge clk);
            n++;
        end while (!(arvalid[p] && arready[p]) && n < WAIT_LIMIT);
        arvalid[p] <= 1'b0;
        if (!(arvalid[p] && arready[p])) begin
            $display("%s port never accepted the read address", port_name(p));
            fails++;
        end else begin
            stall = rand_bits(3);
            repeat (stall) @(posedge clk);
            rready[p] <= 1'b1;
            n = 0;
            do begin
                @(posedge clk);
                n++;
            end while (!(rvalid[p] && rready[p]) && n < WAIT_LIMIT);
            rready[p] <= 1'b0;
            if (!(rvalid[p] && rready[p])) begin
                $display("%s port gave no read response", port_name(p));
                fails++;
            end
        end
    endtask

    task automatic cpu_store(input logic [31:0] a, input axil_data_t d);
        @(posedge clk);
        cpu_addr      <= a;
        cpu_wdata     <= d;
        cpu_wstrb     <= FULL_STRB;
        cpu_mem_write <= 1'b1;
        @(posedge clk);
        cpu_mem_write <= 1'b0;
    endtask

    // one-cycle strobe telling the checker to compare the processor reads
    task automatic probe_cpu(input logic [31:0] pc, input logic [31:0] a);
        @(posedge clk);
        cpu_pc   <= pc;
        cpu_addr <= a;
        @(posedge clk);
        cpu_check <= 1'b1;
        @(posedge clk);
        cpu_check <= 1'b0;
    endtask

    task automatic read_counter_twice();
        repeat (2) begin
            read_txn(CSR_P, REG_CYCLE_LO);
            read_txn(CSR_P, REG_CYCLE_HI);
        end
    endtask

    task automatic test_done(input string name);
        $display("test %-18s finished, %0d failures so far", name,
                 u_checker.errors + fails + props_failures());
    endtask

    function automatic int props_failures();
        return u_emu_top.u_csr_port.u_props.failures + u_emu_top.u_mem_port.u_props.failures;
    endfunction

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= RUN_LIMIT) begin
            $display("run stopped after %0d cycles without finishing", cycles);
            $display("Test FAILED");
            $finish;
        end
    end

    initial begin
        axil_addr_t a;
        axil_strb_t s;
        lfsr          = 32'hf06a;
        fails         = 0;
        cycles        = 0;
        rst           = 1'b1;
        arvalid       = '0;
        rready        = '0;
        awvalid       = '0;
        wvalid        = '0;
        bready        = '0;
        cpu_pc        = '0;
        cpu_addr      = 32'h0000_0100;
        cpu_mem_write = 1'b0;
        cpu_wdata     = '0;
        cpu_wstrb     = '0;
        cpu_check     = 1'b0;
        for (int p = 0; p < 2; p++) begin
            araddr[p] = '0;
            awaddr[p] = '0;
            wdata[p]  = '0;
            wstrb[p]  = '0;
        end
        repeat (5) @(posedge clk);
        rst <= 1'b0;

        read_txn(CSR_P, REG_STAT);
        read_txn(CSR_P, 12'h004);
        for (int i = 0; i < 6; i++) begin
            do begin
                a = axil_addr_t'({rand_bits(10), 2'b00});
            end while (a == REG_STAT || a == REG_CYCLE_LO || a == REG_CYCLE_HI);
            read_txn(CSR_P, a);
        end
        test_done("reset and map");

        write_txn(CSR_P, REG_STAT, 32'h1, FULL_STRB);
        read_counter_twice();
        for (int i = 0; i < 3; i++) begin
            write_txn(CSR_P, REG_CYCLE_LO, rand_bits(32), FULL_STRB);
            write_txn(CSR_P, REG_CYCLE_HI, rand_bits(32), FULL_STRB);
            read_txn(CSR_P, REG_CYCLE_LO);
            read_txn(CSR_P, REG_CYCLE_HI);
        end
        s = axil_strb_t'(rand_bits(4));
        if (s == FULL_STRB) begin
            s = 4'h7;
        end
        write_txn(CSR_P, REG_CYCLE_LO, rand_bits(32), s);
        read_txn(CSR_P, REG_CYCLE_LO);
        test_done("halt and counter");

        for (int i = 0; i < 8; i++) begin
            mem_addrs[i] = axil_addr_t'({rand_bits(10), 2'b00});
            write_txn(MEM_P, mem_addrs[i], rand_bits(32), FULL_STRB);
            write_txn(MEM_P, mem_addrs[i], rand_bits(32), axil_strb_t'(rand_bits(4)));
            read_txn(MEM_P, mem_addrs[i]);
        end
        probe_cpu({20'd0, mem_addrs[3]}, 32'h0000_0100);
        test_done("host memory");

        write_txn(CSR_P, REG_STAT, 32'h0, FULL_STRB);
        write_txn(MEM_P, mem_addrs[5], rand_bits(32), FULL_STRB);
        write_txn(CSR_P, REG_STAT, 32'h1, FULL_STRB);
        read_txn(MEM_P, mem_addrs[5]);
        test_done("host write running");

        write_txn(CSR_P, REG_STAT, 32'h0, FULL_STRB);
        for (int i = 0; i < 4; i++) begin
            a = axil_addr_t'({rand_bits(8) | 32'h1, 4'h0});
            cpu_store({20'd0, a}, rand_bits(32));
            probe_cpu({20'd0, mem_addrs[i]}, {20'd0, a});
        end
        cpu_store(TRIGGER_ADDR, rand_bits(32));
        read_txn(CSR_P, REG_STAT);
        read_txn(MEM_P, TRIGGER_ADDR[11:0]);
        read_counter_twice();
        test_done("trigger");

        $display("%0d checks, %0d mismatches, %0d protocol failures, %0d assertion failures",
                 u_checker.checks, u_checker.errors, fails, props_failures());
        if (u_checker.errors == 0 && fails == 0 && props_failures() == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

// File: filelist.f
emu_pkg.sv
axil_slave_port.sv
emu_csr.sv
emu_mem.sv
emu_top.sv
emu_props.sv
tb_emu_checker.sv
tb_emu_top.sv

// File: run.sh
#!/bin/sh
# build and run the emulation controller testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module tb_emu_top \
    -Mdir obj_dir -f filelist.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/Vtb_emu_top +verilator+error+limit+1000)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qx "Test OK"; then
    exit 0
fi
exit 1
